// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  localparam int SLOTS = 4; // Words per 128-bit line.

  // IF0 to IF1 register.
  typedef struct packed {
    logic [31:0]      pc;
    logic [SLOTS-1:0] slot_valid;
    logic [SLOTS-1:0] slot_jump;
    logic [31:0]      pred_next_pc;
  } fetch_group_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic        pred_jump; // Predicted taken by the BTB.
  } inst_entry_t;

  typedef enum logic [1:0] {
    IDLE, // No response owed to IF1.
    WAIT, // Held group waits for its line.
    DROP  // One stale response to discard.
  } drop_state_e;

endpackage

`default_nettype wire

// ==== src/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_gen import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h1c000000
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              redirect,
  input  wire  [31:0]      redirect_pc,
  input  wire              addr_ok,
  input  wire              if1_free,
  input  wire  [31:0]      pred_next_pc,
  input  wire  [SLOTS-1:0] slot_valid,
  input  wire  [SLOTS-1:0] slot_jump,
  output logic             req,
  output logic [31:0]      req_addr,
  output logic [31:0]      fetch_pc,
  output fetch_group_t     group,
  output logic             group_valid
);

  logic [31:0] pc_r;
  logic        fetch_en;
  logic        accept;

  assign fetch_pc = pc_r;
  assign req_addr = {pc_r[31:4], 4'b0000}; // Line address.
  assign req      = fetch_en && if1_free && !redirect;
  assign accept   = req && addr_ok;

  // Fetch starts one cycle after reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_en <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_r <= RESET_PC;
    end else if (redirect) begin
      pc_r <= redirect_pc;
    end else if (accept) begin
      pc_r <= pred_next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      group_valid <= 1'b0;
    end else if (accept) begin
      group_valid <= 1'b1;
    end else if (if1_free) begin
      group_valid <= 1'b0; // Pushed to the buffer.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      group.pc           <= pc_r;
      group.slot_valid   <= slot_valid;
      group.slot_jump    <= slot_jump;
      group.pred_next_pc <= pred_next_pc;
    end
  end

  // A captured group needs a live slot and its jump inside the live slots.
  assert property (@(posedge clk) disable iff (rst)
    accept |-> (slot_valid != '0) && ((slot_jump & ~slot_valid) == '0));

endmodule

`default_nettype wire

// ==== src/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btb import fetch_pkg::*; #(
  parameter int BTB_DEPTH = 16
) (
  input  wire              clk,
  input  wire              rst,
  input  wire  [31:0]      fetch_pc,
  input  wire              wr,
  input  wire  [31:0]      wr_pc,
  input  wire  [31:0]      wr_target,
  output logic [31:0]      pred_next_pc,
  output logic [SLOTS-1:0] slot_valid,
  output logic [SLOTS-1:0] slot_jump
);

  localparam int OFF_W   = $clog2(SLOTS);
  localparam int BLK_LSB = OFF_W + 2;
  localparam int IDX_W   = $clog2(BTB_DEPTH);
  localparam int TAG_W   = 32 - BLK_LSB - IDX_W;

  logic [BTB_DEPTH-1:0] valid_r;
  logic [TAG_W-1:0]     tag_mem    [BTB_DEPTH];
  logic [OFF_W-1:0]     slot_mem   [BTB_DEPTH];
  logic [31:0]          target_mem [BTB_DEPTH];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic [OFF_W-1:0] offset;
  logic [OFF_W-1:0] hit_slot;
  logic             hit;

  assign rd_idx   = fetch_pc[BLK_LSB +: IDX_W];
  assign wr_idx   = wr_pc[BLK_LSB +: IDX_W];
  assign offset   = fetch_pc[2 +: OFF_W];
  assign hit_slot = slot_mem[rd_idx];
  // A branch before the entry point of the line does not count.
  assign hit = valid_r[rd_idx] && (tag_mem[rd_idx] == fetch_pc[31 -: TAG_W]) &&
               (hit_slot >= offset);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= '0;
    end else if (wr) begin
      valid_r[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      tag_mem[wr_idx]    <= wr_pc[31 -: TAG_W];
      slot_mem[wr_idx]   <= wr_pc[2 +: OFF_W];
      target_mem[wr_idx] <= wr_target;
    end
  end

  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      slot_valid[i] = (i >= offset) && (!hit || i <= hit_slot);
      slot_jump[i]  = hit && (i == hit_slot);
    end
  end

  assign pred_next_pc = hit ? target_mem[rd_idx]
                            : {fetch_pc[31:BLK_LSB] + 1'b1, {BLK_LSB{1'b0}}};

endmodule

`default_nettype wire

// ==== src/fetch_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_align import fetch_pkg::*; #(
  parameter int IB_DEPTH = 16
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       redirect,
  input  wire  fetch_group_t        group,
  input  wire                       group_valid,
  input  wire                       req_accepted,
  input  wire                       data_ok,
  input  wire  [127:0]              rdata,
  input  wire  [$clog2(IB_DEPTH):0] free_count,
  output logic                      if1_free,
  output logic [2:0]                push_num,
  output inst_entry_t [SLOTS-1:0]   push_entries
);

  localparam int OFF_W = $clog2(SLOTS);

  drop_state_e  state;
  logic         held;
  logic [127:0] rdata_r;
  logic [127:0] blk_data;
  logic         data_here;
  logic [2:0]   group_cnt;
  logic         push_ok;

  assign data_here = held || (state == WAIT && data_ok);
  assign blk_data  = held ? rdata_r : rdata;
  assign push_ok   = group_valid && data_here && (group_cnt <= free_count);
  assign push_num  = push_ok ? group_cnt : 3'd0;
  // No new request until a stale response has gone by.
  assign if1_free  = (state != DROP) && (!group_valid || push_ok);

  always_comb begin
    group_cnt = 3'd0;
    for (int i = 0; i < SLOTS; i++) begin
      group_cnt = group_cnt + {2'b00, group.slot_valid[i]};
    end
  end

  // Valid slots are contiguous from the entry offset, so rotate them down.
  always_comb begin : build_entries
    logic [OFF_W-1:0] s;
    for (int k = 0; k < SLOTS; k++) begin
      s = group.pc[2 +: OFF_W] + OFF_W'(k);
      push_entries[k].pc        = {group.pc[31:OFF_W+2], s, 2'b00};
      push_entries[k].inst      = blk_data[32*s +: 32];
      push_entries[k].pred_jump = group.slot_jump[s];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      held  <= 1'b0;
    end else if (redirect) begin
      state <= (state != IDLE && !data_ok) ? DROP : IDLE;
      held  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req_accepted) begin
            state <= WAIT;
          end
        end
        WAIT: begin
          if (data_ok && !(push_ok && req_accepted)) begin
            state <= IDLE; // Line pushed or latched.
          end
        end
        DROP: begin
          if (data_ok) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
      if (push_ok) begin
        held <= 1'b0;
      end else if (state == WAIT && data_ok) begin
        held <= 1'b1; // Buffer too full.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == WAIT && data_ok) begin
      rdata_r <= rdata;
    end
  end

  // Rotation needs the valid slots to run on from the entry offset.
  assert property (@(posedge clk) disable iff (rst)
    group_valid |-> group.slot_valid ==
      SLOTS'(((32'd1 << group_cnt) - 32'd1) << group.pc[2 +: OFF_W]));

  // Every response from the cache must match a tracked request.
  assert property (@(posedge clk) disable iff (rst) data_ok |-> state != IDLE);

endmodule

`default_nettype wire

// ==== src/inst_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_buffer import fetch_pkg::*; #(
  parameter int IB_DEPTH = 16
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       flush,
  input  wire  [2:0]                push_num,
  input  wire  inst_entry_t [SLOTS-1:0] push_entries,
  input  wire                       out_ready,
  output logic [$clog2(IB_DEPTH):0] free_count,
  output logic                      out_valid,
  output inst_entry_t               out_entry
);

  localparam int AW = $clog2(IB_DEPTH);

  inst_entry_t   mem [IB_DEPTH];
  logic [AW-1:0] head;
  logic [AW-1:0] tail;
  logic [AW:0]   count;
  logic          pop;

  assign out_valid  = (count != '0);
  assign out_entry  = mem[head];
  assign pop        = out_valid && out_ready;
  assign free_count = (AW+1)'(IB_DEPTH) - count;

  // Pushes land at consecutive slots from the tail.
  always_ff @(posedge clk) begin
    for (int i = 0; i < SLOTS; i++) begin
      if (i < push_num) begin
        mem[tail + AW'(i)] <= push_entries[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      tail  <= tail + AW'(push_num);
      count <= count + (AW+1)'(push_num) - (AW+1)'(pop);
    end
  end

  // Holds only if IF1 never pushes past the reported space.
  assert property (@(posedge clk) disable iff (rst) count <= (AW+1)'(IB_DEPTH));

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC  = 32'h1c000000,
  parameter int          BTB_DEPTH = 16,
  parameter int          IB_DEPTH  = 16
) (
  input  wire          clk,
  input  wire          rst,
  output logic         req,
  output logic [31:0]  req_addr,
  input  wire          addr_ok,
  input  wire          data_ok,
  input  wire  [127:0] rdata,
  input  wire          redirect,
  input  wire  [31:0]  redirect_pc,
  input  wire          btb_wr,
  input  wire  [31:0]  btb_wr_pc,
  input  wire  [31:0]  btb_wr_target,
  output logic         out_valid,
  output inst_entry_t  out_entry,
  input  wire          out_ready
);

  logic [31:0]             fetch_pc;
  logic [31:0]             pred_next_pc;
  logic [SLOTS-1:0]        slot_valid;
  logic [SLOTS-1:0]        slot_jump;
  fetch_group_t            group;
  logic                    group_valid;
  logic                    if1_free;
  logic                    req_accepted;
  logic [2:0]              push_num;
  inst_entry_t [SLOTS-1:0] push_entries;
  logic [$clog2(IB_DEPTH):0] free_count;

  assign req_accepted = req && addr_ok;

  pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
    .clk(clk), .rst(rst),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .addr_ok(addr_ok), .if1_free(if1_free),
    .pred_next_pc(pred_next_pc), .slot_valid(slot_valid), .slot_jump(slot_jump),
    .req(req), .req_addr(req_addr), .fetch_pc(fetch_pc),
    .group(group), .group_valid(group_valid)
  );

  btb #(.BTB_DEPTH(BTB_DEPTH)) u_btb (
    .clk(clk), .rst(rst), .fetch_pc(fetch_pc),
    .wr(btb_wr), .wr_pc(btb_wr_pc), .wr_target(btb_wr_target),
    .pred_next_pc(pred_next_pc), .slot_valid(slot_valid), .slot_jump(slot_jump)
  );

  fetch_align #(.IB_DEPTH(IB_DEPTH)) u_fetch_align (
    .clk(clk), .rst(rst), .redirect(redirect),
    .group(group), .group_valid(group_valid), .req_accepted(req_accepted),
    .data_ok(data_ok), .rdata(rdata), .free_count(free_count),
    .if1_free(if1_free), .push_num(push_num), .push_entries(push_entries)
  );

  // Redirect empties the buffer at the same edge as IF1.
  inst_buffer #(.IB_DEPTH(IB_DEPTH)) u_inst_buffer (
    .clk(clk), .rst(rst), .flush(redirect),
    .push_num(push_num), .push_entries(push_entries), .out_ready(out_ready),
    .free_count(free_count), .out_valid(out_valid), .out_entry(out_entry)
  );

endmodule

`default_nettype wire

// ==== tb/icache_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_model (
  input  wire          clk,
  input  wire          rst,
  input  wire          req,
  input  wire  [31:0]  req_addr,
  input  wire          addr_ok,
  input  wire  [2:0]   delay,
  output logic         data_ok = 1'b0,
  output logic [127:0] rdata = '0
);

  logic [31:0] addr_q [$];
  int          due_q  [$];
  int          cycle = 0;
  int          due = 0;
  logic        hit;

  always @(posedge clk) begin
    cycle = rst ? 0 : cycle + 1;
    if (rst) begin
      addr_q.delete();
      due_q.delete();
      due = 0;
    end else if (req && addr_ok) begin
      // Responses leave in request order.
      due = (cycle + delay - 1 > due) ? cycle + delay - 1 : due + 1;
      addr_q.push_back(req_addr);
      due_q.push_back(due);
    end
    hit = (due_q.size() != 0) && (due_q[0] == cycle);
    #2;
    data_ok = hit;
    if (hit) begin
      for (int i = 0; i < 4; i++) begin
        rdata[32*i +: 32] = (addr_q[0] + 32'(4 * i)) ^ 32'h5a5a0000;
      end
      void'(addr_q.pop_front());
      void'(due_q.pop_front());
    end
  end

endmodule

`default_nettype wire

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

  localparam logic [31:0] RESET_PC = 32'h1c000000;
  localparam int          PHASES   = 5;

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  logic         req;
  logic [31:0]  req_addr;
  logic         addr_ok = 1'b0;
  logic         data_ok;
  logic [127:0] rdata;
  logic         redirect = 1'b0;
  logic [31:0]  redirect_pc = '0;
  logic         btb_wr = 1'b0;
  logic [31:0]  btb_wr_pc = '0;
  logic [31:0]  btb_wr_target = '0;
  logic         out_valid;
  inst_entry_t  out_entry;
  logic         out_ready = 1'b0;
  logic [2:0]   delay = 3'd1;

  logic [31:0] rnd = 32'hd06bc366;
  logic [1:0]  mode = 2'd0; // 0 steady, 1 random, 2 stalled, 3 slow cache.
  logic [31:0] exp_pc;
  logic        exp_jump;
  logic        acc_seen;
  logic        hold_chk = 1'b0;
  int          n_out = 0;
  logic [31:0] br_pc  [8];
  logic [31:0] br_tgt [8];
  int          br_cnt = 0;
  logic        xfer;

  assign xfer = out_valid && out_ready;

  fetch_top #(.RESET_PC(RESET_PC), .BTB_DEPTH(16), .IB_DEPTH(16)) UUT (
    .clk(clk), .rst(rst), .req(req), .req_addr(req_addr), .addr_ok(addr_ok),
    .data_ok(data_ok), .rdata(rdata), .redirect(redirect), .redirect_pc(redirect_pc),
    .btb_wr(btb_wr), .btb_wr_pc(btb_wr_pc), .btb_wr_target(btb_wr_target),
    .out_valid(out_valid), .out_entry(out_entry), .out_ready(out_ready)
  );

  icache_model cache (
    .clk(clk), .rst(rst), .req(req), .req_addr(req_addr), .addr_ok(addr_ok),
    .delay(delay), .data_ok(data_ok), .rdata(rdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic has_branch(input logic [31:0] pc);
    for (int i = 0; i < br_cnt; i++) begin
      if (br_pc[i] == pc) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] follow_pc(input logic [31:0] pc);
    for (int i = 0; i < br_cnt; i++) begin
      if (br_pc[i] == pc) begin
        return br_tgt[i]; // Trained branch is always taken.
      end
    end
    return pc + 32'd4;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s: got %h, expected %h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic run_outputs(input int n);
    int target;
    target = n_out + n;
    while (n_out < target) begin
      step();
    end
  endtask

  task automatic redirect_to(input logic [31:0] pc, input logic train,
                             input logic [31:0] bpc, input logic [31:0] btgt);
    redirect = 1'b1;
    redirect_pc = pc;
    btb_wr = train;
    btb_wr_pc = bpc;
    btb_wr_target = btgt;
    step();
    redirect = 1'b0;
    btb_wr = 1'b0;
  endtask

  initial begin
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin : random_drive
    logic [1:0] m;
    m = mode; // Mode as it stood before the edge.
    #2;
    rnd = xorshift(rnd);
    delay = (m == 2'd3) ? 3'd4 : {1'b0, rnd[3:2]} + 3'd1;
    addr_ok = (m == 2'd0) || (m == 2'd3) || rnd[0] || rnd[1];
    out_ready = (m == 2'd0) || (m == 2'd3) || (m == 2'd1 && (rnd[4] || rnd[5]));
  end

  always @(posedge clk) begin : ref_model
    logic [31:0] nxt;
    if (rst) begin
      br_cnt = 0;
      nxt = RESET_PC;
    end else begin
      if (btb_wr) begin
        br_pc[br_cnt] = btb_wr_pc;
        br_tgt[br_cnt] = btb_wr_target;
        br_cnt = br_cnt + 1;
      end
      nxt = redirect ? redirect_pc : (xfer ? follow_pc(exp_pc) : exp_pc);
    end
    if (xfer) begin
      n_out <= n_out + 1;
    end
    acc_seen <= req && addr_ok;
    exp_pc <= nxt;
    exp_jump <= has_branch(nxt);
  end

  assert property (@(posedge clk) rst |=> !req)
    else report_mismatch("req", 32'($sampled(req)), 32'h0);
  assert property (@(posedge clk) rst |=> !out_valid)
    else report_mismatch("out_valid", 32'($sampled(out_valid)), 32'h0);
  // Cache requests are whole 16-byte lines.
  assert property (@(posedge clk) disable iff (rst) req |-> req_addr[3:0] == 4'h0)
    else report_mismatch("req_addr", $sampled(req_addr),
                         {$sampled(req_addr[31:4]), 4'h0});
  assert property (@(posedge clk) disable iff (rst) xfer |-> out_entry.pc == exp_pc)
    else report_mismatch("out_entry.pc", $sampled(out_entry.pc), $sampled(exp_pc));
  assert property (@(posedge clk) disable iff (rst)
    xfer |-> out_entry.inst == (exp_pc ^ 32'h5a5a0000))
    else report_mismatch("out_entry.inst", $sampled(out_entry.inst),
                         $sampled(exp_pc) ^ 32'h5a5a0000);
  assert property (@(posedge clk) disable iff (rst) xfer |-> out_entry.pred_jump == exp_jump)
    else report_mismatch("out_entry.pred_jump", 32'($sampled(out_entry.pred_jump)),
                         32'($sampled(exp_jump)));
  // Full buffer must stop all fetching.
  assert property (@(posedge clk) disable iff (rst) hold_chk |-> !req)
    else report_mismatch("req", 32'($sampled(req)), 32'h0);

  initial begin : watchdog
    #(PHASES * 2000 * 40);
    $display("Watchdog expired, the fetch stream stopped making progress");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    run_outputs(40);
    redirect_to(32'h1c00010c, 1'b0, '0, '0); // Last word of a line.
    run_outputs(12);
    mode = 2'd3;
    repeat (3) step();
    do begin
      step();
    end while (!acc_seen);
    redirect_to(32'h1c000404, 1'b0, '0, '0); // Line still owed by the cache.
    run_outputs(12);
    mode = 2'd0;
    redirect_to(32'h1c000200, 1'b1, 32'h1c000208, 32'h1c000104);
    redirect_to(32'h1c000200, 1'b1, 32'h1c000124, 32'h1c00020c);
    run_outputs(30);
    mode = 2'd1;
    run_outputs(200);
    mode = 2'd2;
    repeat (100) step();
    hold_chk = 1'b1;
    repeat (50) step();
    hold_chk = 1'b0;
    mode = 2'd1;
    run_outputs(40);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
common/fetch_pkg.sv
src/pc_gen.sv
src/btb.sv
src/fetch_align.sv
src/inst_buffer.sv
src/fetch_top.sv
tb/icache_model.sv
tb/fetch_tb.sv
